// ==== rtl/rf_cfg_pkg.sv ====
// address layout is {row, half, tile} from msb to lsb; the bank row field is fixed at 4 bits
`default_nettype none

package rf_cfg_pkg;

  // register width used when the top level does not override it
  parameter int DEFAULT_DATA_WIDTH = 32;

  // tile index field, lowest bits of the register address
  parameter int DEFAULT_TILE_BITS = 2;

  // bank select inside a tile, sits just above the tile field
  parameter int HALF_BITS = 1;

  // row inside one bank; rf_row_ram is built for exactly 16 rows
  parameter int ROW_BITS = 4;

endpackage

`default_nettype wire

// ==== rtl/rf_types_pkg.sv ====
// control encodings only; values are internal and never cross the external ports
`default_nettype none

package rf_types_pkg;

  // zero-fill sequencer
  typedef enum logic
  {
    sweep_fill,
    sweep_done
  } sweep_state_e;

  // where a read port takes its data from
  typedef enum logic [1:0]
  {
    src_none,
    src_tile,
    src_const
  } read_src_e;

endpackage

`default_nettype wire

// ==== rtl/rf_row_ram.sv ====
// 16-row bank, write first; data follows the array live, advance enables only gate the rows
`timescale 1ns/1ps
`default_nettype none

module rf_row_ram #(
  parameter int DATA_WIDTH = rf_cfg_pkg::DEFAULT_DATA_WIDTH
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            read_advance,
  input  logic                            retire_advance,
  input  logic [rf_cfg_pkg::ROW_BITS-1:0] read0_row,
  input  logic [rf_cfg_pkg::ROW_BITS-1:0] read1_row,
  input  logic [rf_cfg_pkg::ROW_BITS-1:0] retire_row,
  output logic [DATA_WIDTH-1:0]           read0_data,
  output logic [DATA_WIDTH-1:0]           read1_data,
  output logic [DATA_WIDTH-1:0]           retire_data,
  input  logic [rf_cfg_pkg::ROW_BITS-1:0] write0_row,
  input  logic [DATA_WIDTH-1:0]           write0_data,
  input  logic                            write0_en,
  input  logic [rf_cfg_pkg::ROW_BITS-1:0] write1_row,
  input  logic [DATA_WIDTH-1:0]           write1_data,
  input  logic                            write1_en
);
  import rf_cfg_pkg::*;

  localparam int ROW_COUNT = 1 << ROW_BITS;

  logic [DATA_WIDTH-1:0] mem [ROW_COUNT];

  logic [ROW_BITS-1:0] read0_row_q;
  logic [ROW_BITS-1:0] read1_row_q;
  logic [ROW_BITS-1:0] retire_row_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      read0_row_q  <= '0;
      read1_row_q  <= '0;
      retire_row_q <= '0;
    end
    else
    begin
      if (read_advance)
      begin
        read0_row_q <= read0_row;
        read1_row_q <= read1_row;
      end
      // retire side runs on its own enable
      if (retire_advance)
      begin
        retire_row_q <= retire_row;
      end
    end
  end

  // port 1 last, so it wins a same-row collision
  always_ff @(posedge clk)
  begin
    if (write0_en)
    begin
      mem[write0_row] <= write0_data;
    end
    if (write1_en)
    begin
      mem[write1_row] <= write1_data;
    end
  end

  assign read0_data  = mem[read0_row_q];
  assign read1_data  = mem[read1_row_q];
  assign retire_data = mem[retire_row_q];

endmodule

`default_nettype wire

// ==== rtl/rf_tile.sv ====
// one tile of two banks; hit flags are registered with the rows, const override lives in the merge
`timescale 1ns/1ps
`default_nettype none

module rf_tile #(
  parameter int  DATA_WIDTH = rf_cfg_pkg::DEFAULT_DATA_WIDTH,
  parameter int  TILE_BITS  = rf_cfg_pkg::DEFAULT_TILE_BITS,
  parameter int  TILE_INDEX = 0,
  localparam int ADDR_WIDTH = TILE_BITS + rf_cfg_pkg::HALF_BITS + rf_cfg_pkg::ROW_BITS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  read_advance,
  input  logic                  retire_advance,
  input  logic [ADDR_WIDTH-1:0] read0_addr,
  input  logic [ADDR_WIDTH-1:0] read1_addr,
  input  logic [ADDR_WIDTH-1:0] retire_addr,
  output logic                  read0_hit,
  output logic                  read1_hit,
  output logic                  retire_hit,
  output logic [DATA_WIDTH-1:0] read0_data,
  output logic [DATA_WIDTH-1:0] read1_data,
  output logic [DATA_WIDTH-1:0] retire_data,
  input  logic [ADDR_WIDTH-1:0] write0_addr,
  input  logic [DATA_WIDTH-1:0] write0_data,
  input  logic                  write0_en,
  input  logic [ADDR_WIDTH-1:0] write1_addr,
  input  logic [DATA_WIDTH-1:0] write1_data,
  input  logic                  write1_en
);
  import rf_cfg_pkg::*;

  localparam int ROW_LSB = TILE_BITS + HALF_BITS;
  localparam logic [TILE_BITS-1:0] TILE_ID = TILE_BITS'(TILE_INDEX);

  logic write0_en_a;
  logic write0_en_b;
  logic write1_en_a;
  logic write1_en_b;

  logic read0_hit_q;
  logic read1_hit_q;
  logic retire_hit_q;
  logic read0_half_q;
  logic read1_half_q;
  logic retire_half_q;

  logic [DATA_WIDTH-1:0] a_read0_data;
  logic [DATA_WIDTH-1:0] a_read1_data;
  logic [DATA_WIDTH-1:0] a_retire_data;
  logic [DATA_WIDTH-1:0] b_read0_data;
  logic [DATA_WIDTH-1:0] b_read1_data;
  logic [DATA_WIDTH-1:0] b_retire_data;

  function automatic logic tile_match(input logic [ADDR_WIDTH-1:0] addr);
    return addr[TILE_BITS-1:0] == TILE_ID;
  endfunction

  // half bit low selects bank A
  assign write0_en_a = write0_en && tile_match(write0_addr) && !write0_addr[TILE_BITS];
  assign write0_en_b = write0_en && tile_match(write0_addr) && write0_addr[TILE_BITS];
  assign write1_en_a = write1_en && tile_match(write1_addr) && !write1_addr[TILE_BITS];
  assign write1_en_b = write1_en && tile_match(write1_addr) && write1_addr[TILE_BITS];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      read0_hit_q   <= 1'b0;
      read1_hit_q   <= 1'b0;
      retire_hit_q  <= 1'b0;
      read0_half_q  <= 1'b0;
      read1_half_q  <= 1'b0;
      retire_half_q <= 1'b0;
    end
    else
    begin
      if (read_advance)
      begin
        read0_hit_q  <= tile_match(read0_addr);
        read1_hit_q  <= tile_match(read1_addr);
        read0_half_q <= read0_addr[TILE_BITS];
        read1_half_q <= read1_addr[TILE_BITS];
      end
      if (retire_advance)
      begin
        retire_hit_q  <= tile_match(retire_addr);
        retire_half_q <= retire_addr[TILE_BITS];
      end
    end
  end

  rf_row_ram #(
    .DATA_WIDTH(DATA_WIDTH)
  ) bank_a_inst (
    .clk            (clk),
    .rst            (rst),
    .read_advance   (read_advance),
    .retire_advance (retire_advance),
    .read0_row      (read0_addr[ADDR_WIDTH-1:ROW_LSB]),
    .read1_row      (read1_addr[ADDR_WIDTH-1:ROW_LSB]),
    .retire_row     (retire_addr[ADDR_WIDTH-1:ROW_LSB]),
    .read0_data     (a_read0_data),
    .read1_data     (a_read1_data),
    .retire_data    (a_retire_data),
    .write0_row     (write0_addr[ADDR_WIDTH-1:ROW_LSB]),
    .write0_data    (write0_data),
    .write0_en      (write0_en_a),
    .write1_row     (write1_addr[ADDR_WIDTH-1:ROW_LSB]),
    .write1_data    (write1_data),
    .write1_en      (write1_en_a)
  );

  rf_row_ram #(
    .DATA_WIDTH(DATA_WIDTH)
  ) bank_b_inst (
    .clk            (clk),
    .rst            (rst),
    .read_advance   (read_advance),
    .retire_advance (retire_advance),
    .read0_row      (read0_addr[ADDR_WIDTH-1:ROW_LSB]),
    .read1_row      (read1_addr[ADDR_WIDTH-1:ROW_LSB]),
    .retire_row     (retire_addr[ADDR_WIDTH-1:ROW_LSB]),
    .read0_data     (b_read0_data),
    .read1_data     (b_read1_data),
    .retire_data    (b_retire_data),
    .write0_row     (write0_addr[ADDR_WIDTH-1:ROW_LSB]),
    .write0_data    (write0_data),
    .write0_en      (write0_en_b),
    .write1_row     (write1_addr[ADDR_WIDTH-1:ROW_LSB]),
    .write1_data    (write1_data),
    .write1_en      (write1_en_b)
  );

  assign read0_hit   = read0_hit_q;
  assign read1_hit   = read1_hit_q;
  assign retire_hit  = retire_hit_q;
  assign read0_data  = read0_half_q ? b_read0_data : a_read0_data;
  assign read1_data  = read1_half_q ? b_read1_data : a_read1_data;
  assign retire_data = retire_half_q ? b_retire_data : a_retire_data;

  // an unknown address on an enabled write would steer it into neither or both banks
  assert property (@(posedge clk) disable iff (rst)
    write0_en |-> !$isunknown(write0_addr))
    else $error("tile %0d: write0 enabled with an unknown address", TILE_INDEX);

  assert property (@(posedge clk) disable iff (rst)
    write1_en |-> !$isunknown(write1_addr))
    else $error("tile %0d: write1 enabled with an unknown address", TILE_INDEX);

endmodule

`default_nettype wire

// ==== rtl/rf_init_sweep.sv ====
// zero-fills every address after reset through write port 0; external write1 must idle until ready
`timescale 1ns/1ps
`default_nettype none

module rf_init_sweep #(
  parameter int  DATA_WIDTH = rf_cfg_pkg::DEFAULT_DATA_WIDTH,
  parameter int  TILE_BITS  = rf_cfg_pkg::DEFAULT_TILE_BITS,
  localparam int ADDR_WIDTH = TILE_BITS + rf_cfg_pkg::HALF_BITS + rf_cfg_pkg::ROW_BITS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [ADDR_WIDTH-1:0] write0_addr,
  input  logic [DATA_WIDTH-1:0] write0_data,
  input  logic                  write0_en,
  output logic [ADDR_WIDTH-1:0] sweep_addr,
  output logic [DATA_WIDTH-1:0] sweep_data,
  output logic                  sweep_en,
  output logic                  ready
);
  import rf_types_pkg::*;

  sweep_state_e          state_q;
  logic [ADDR_WIDTH-1:0] count_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= sweep_fill;
      count_q <= '0;
    end
    else if (state_q == sweep_fill)
    begin
      count_q <= count_q + ADDR_WIDTH'(1);
      // last address written this cycle
      if (count_q == '1)
      begin
        state_q <= sweep_done;
      end
    end
  end

  // external port 0 is dropped while filling
  assign sweep_addr = (state_q == sweep_fill) ? count_q : write0_addr;
  assign sweep_data = (state_q == sweep_fill) ? '0 : write0_data;
  assign sweep_en   = (state_q == sweep_fill) || write0_en;
  assign ready      = (state_q == sweep_done);

  assert property (@(posedge clk) disable iff (rst)
    (state_q == sweep_fill && count_q == '1) |=> (state_q == sweep_done))
    else $error("sweep counter wrapped while still filling");

  assert property (@(posedge clk) disable iff (rst)
    ready |=> ready)
    else $error("ready dropped without a reset");

endmodule

`default_nettype wire

// ==== rtl/rf_read_merge.sv ====
// picks const or the hitting tile per port; no hit and no const gives zero, retire never uses const
`timescale 1ns/1ps
`default_nettype none

module rf_read_merge #(
  parameter int  DATA_WIDTH = rf_cfg_pkg::DEFAULT_DATA_WIDTH,
  parameter int  TILE_BITS  = rf_cfg_pkg::DEFAULT_TILE_BITS,
  localparam int NUM_TILES  = 1 << TILE_BITS
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            read_advance,
  input  logic                            read0_const_en,
  input  logic [DATA_WIDTH-1:0]           read0_const,
  input  logic                            read1_const_en,
  input  logic [DATA_WIDTH-1:0]           read1_const,
  input  logic [NUM_TILES-1:0]            read0_hit,
  input  logic [NUM_TILES-1:0]            read1_hit,
  input  logic [NUM_TILES-1:0]            retire_hit,
  input  logic [NUM_TILES*DATA_WIDTH-1:0] tile_read0_data,
  input  logic [NUM_TILES*DATA_WIDTH-1:0] tile_read1_data,
  input  logic [NUM_TILES*DATA_WIDTH-1:0] tile_retire_data,
  output logic [DATA_WIDTH-1:0]           read0_data,
  output logic [DATA_WIDTH-1:0]           read1_data,
  output logic [DATA_WIDTH-1:0]           retire_data
);
  import rf_types_pkg::*;

  logic                  read0_const_en_q;
  logic                  read1_const_en_q;
  logic [DATA_WIDTH-1:0] read0_const_q;
  logic [DATA_WIDTH-1:0] read1_const_q;
  read_src_e             read0_src;
  read_src_e             read1_src;

  function automatic logic [DATA_WIDTH-1:0] pick_tile(
    input logic [NUM_TILES-1:0]            hit,
    input logic [NUM_TILES*DATA_WIDTH-1:0] data
  );
    logic [DATA_WIDTH-1:0] result;
    result = '0;
    for (int t = 0; t < NUM_TILES; t++)
    begin
      if (hit[t])
      begin
        result = result | data[t*DATA_WIDTH +: DATA_WIDTH];
      end
    end
    return result;
  endfunction

  function automatic read_src_e choose_src(input logic const_en, input logic any_hit);
    if (const_en)
    begin
      return src_const;
    end
    return any_hit ? src_tile : src_none;
  endfunction

  // captured on the same edge as the tile addresses
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      read0_const_en_q <= 1'b0;
      read1_const_en_q <= 1'b0;
    end
    else if (read_advance)
    begin
      read0_const_en_q <= read0_const_en;
      read1_const_en_q <= read1_const_en;
    end
  end

  always_ff @(posedge clk)
  begin
    if (read_advance)
    begin
      read0_const_q <= read0_const;
      read1_const_q <= read1_const;
    end
  end

  assign read0_src = choose_src(read0_const_en_q, |read0_hit);
  assign read1_src = choose_src(read1_const_en_q, |read1_hit);

  always_comb
  begin
    case (read0_src)
      src_const: read0_data = read0_const_q;
      src_tile:  read0_data = pick_tile(read0_hit, tile_read0_data);
      default:   read0_data = '0;
    endcase
    case (read1_src)
      src_const: read1_data = read1_const_q;
      src_tile:  read1_data = pick_tile(read1_hit, tile_read1_data);
      default:   read1_data = '0;
    endcase
  end

  assign retire_data = pick_tile(retire_hit, tile_retire_data);

  // tiles decode independently, so only one may claim a port
  assert property (@(posedge clk) disable iff (rst) $onehot0(read0_hit))
    else $error("read0: more than one tile hit");
  assert property (@(posedge clk) disable iff (rst) $onehot0(read1_hit))
    else $error("read1: more than one tile hit");
  assert property (@(posedge clk) disable iff (rst) $onehot0(retire_hit))
    else $error("retire: more than one tile hit");

endmodule

`default_nettype wire

// ==== rtl/rf_bank.sv ====
// tiled register file top; reads valid one edge after capture, ready low 2^addr_width cycles
`timescale 1ns/1ps
`default_nettype none

module rf_bank #(
  parameter int  DATA_WIDTH = rf_cfg_pkg::DEFAULT_DATA_WIDTH,
  parameter int  TILE_BITS  = rf_cfg_pkg::DEFAULT_TILE_BITS,
  localparam int ADDR_WIDTH = TILE_BITS + rf_cfg_pkg::HALF_BITS + rf_cfg_pkg::ROW_BITS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  read_advance,
  input  logic [ADDR_WIDTH-1:0] read0_addr,
  input  logic                  read0_const_en,
  input  logic [DATA_WIDTH-1:0] read0_const,
  output logic [DATA_WIDTH-1:0] read0_data,
  input  logic [ADDR_WIDTH-1:0] read1_addr,
  input  logic                  read1_const_en,
  input  logic [DATA_WIDTH-1:0] read1_const,
  output logic [DATA_WIDTH-1:0] read1_data,
  input  logic                  retire_advance,
  input  logic [ADDR_WIDTH-1:0] retire_addr,
  output logic [DATA_WIDTH-1:0] retire_data,
  input  logic [ADDR_WIDTH-1:0] write0_addr,
  input  logic [DATA_WIDTH-1:0] write0_data,
  input  logic                  write0_en,
  input  logic [ADDR_WIDTH-1:0] write1_addr,
  input  logic [DATA_WIDTH-1:0] write1_data,
  input  logic                  write1_en,
  output logic                  ready
);
  localparam int NUM_TILES = 1 << TILE_BITS;

  logic [ADDR_WIDTH-1:0] sweep_addr;
  logic [DATA_WIDTH-1:0] sweep_data;
  logic                  sweep_en;

  logic [NUM_TILES-1:0]            read0_hit;
  logic [NUM_TILES-1:0]            read1_hit;
  logic [NUM_TILES-1:0]            retire_hit;
  logic [NUM_TILES*DATA_WIDTH-1:0] tile_read0_data;
  logic [NUM_TILES*DATA_WIDTH-1:0] tile_read1_data;
  logic [NUM_TILES*DATA_WIDTH-1:0] tile_retire_data;

  rf_init_sweep #(
    .DATA_WIDTH(DATA_WIDTH),
    .TILE_BITS (TILE_BITS)
  ) sweep_inst (
    .clk         (clk),
    .rst         (rst),
    .write0_addr (write0_addr),
    .write0_data (write0_data),
    .write0_en   (write0_en),
    .sweep_addr  (sweep_addr),
    .sweep_data  (sweep_data),
    .sweep_en    (sweep_en),
    .ready       (ready)
  );

  // every tile sees every write and decodes its own index
  for (genvar t = 0; t < NUM_TILES; t++)
  begin : g_tile
    rf_tile #(
      .DATA_WIDTH(DATA_WIDTH),
      .TILE_BITS (TILE_BITS),
      .TILE_INDEX(t)
    ) tile_inst (
      .clk            (clk),
      .rst            (rst),
      .read_advance   (read_advance),
      .retire_advance (retire_advance),
      .read0_addr     (read0_addr),
      .read1_addr     (read1_addr),
      .retire_addr    (retire_addr),
      .read0_hit      (read0_hit[t]),
      .read1_hit      (read1_hit[t]),
      .retire_hit     (retire_hit[t]),
      .read0_data     (tile_read0_data[t*DATA_WIDTH +: DATA_WIDTH]),
      .read1_data     (tile_read1_data[t*DATA_WIDTH +: DATA_WIDTH]),
      .retire_data    (tile_retire_data[t*DATA_WIDTH +: DATA_WIDTH]),
      .write0_addr    (sweep_addr),
      .write0_data    (sweep_data),
      .write0_en      (sweep_en),
      .write1_addr    (write1_addr),
      .write1_data    (write1_data),
      .write1_en      (write1_en)
    );
  end

  rf_read_merge #(
    .DATA_WIDTH(DATA_WIDTH),
    .TILE_BITS (TILE_BITS)
  ) merge_inst (
    .clk              (clk),
    .rst              (rst),
    .read_advance     (read_advance),
    .read0_const_en   (read0_const_en),
    .read0_const      (read0_const),
    .read1_const_en   (read1_const_en),
    .read1_const      (read1_const),
    .read0_hit        (read0_hit),
    .read1_hit        (read1_hit),
    .retire_hit       (retire_hit),
    .tile_read0_data  (tile_read0_data),
    .tile_read1_data  (tile_read1_data),
    .tile_retire_data (tile_retire_data),
    .read0_data       (read0_data),
    .read1_data       (read1_data),
    .retire_data      (retire_data)
  );

endmodule

`default_nettype wire

// ==== verification/rf_bank_tb.sv ====
// assumes the default sizes (128 addresses); read ports are checked every falling edge after the sweep
`timescale 1ns/1ps
`default_nettype none

module rf_bank_tb;
  import rf_cfg_pkg::*;
  import rf_types_pkg::*;

  localparam int addr_width    = DEFAULT_TILE_BITS + HALF_BITS + ROW_BITS;
  localparam int data_width    = DEFAULT_DATA_WIDTH;
  localparam int num_addr      = 1 << addr_width;
  localparam int half_period   = 50;
  localparam int reset_cycles  = 8;
  localparam int random_ops    = 500;
  localparam int const_ops     = 300;
  localparam int stall_rounds  = 60;
  localparam int retire_rounds = 80;
  // stall rounds take 8 cycles, retire rounds 5, the sweep and the zero readback one pass each
  localparam int expected_cycles = reset_cycles + 2 * num_addr + 2 * random_ops + const_ops
                                   + 8 * stall_rounds + 5 * retire_rounds;
  localparam int cycle_limit = 2 * expected_cycles;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;

  logic  clk;
  logic  rst;
  logic  read_advance;
  addr_t read0_addr;
  logic  read0_const_en;
  data_t read0_const;
  data_t read0_data;
  addr_t read1_addr;
  logic  read1_const_en;
  data_t read1_const;
  data_t read1_data;
  logic  retire_advance;
  addr_t retire_addr;
  data_t retire_data;
  addr_t write0_addr;
  data_t write0_data;
  logic  write0_en;
  addr_t write1_addr;
  data_t write1_data;
  logic  write1_en;
  logic  ready;

  // reference model state
  data_t shadow [num_addr];
  int    sweep_left;
  logic  cap_valid;
  logic  retire_valid;
  addr_t cap0_addr;
  addr_t cap1_addr;
  addr_t cap_retire_addr;
  logic  cap0_const_en;
  logic  cap1_const_en;
  data_t cap0_const;
  data_t cap1_const;

  int seed;
  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;

  rf_bank #(
    .DATA_WIDTH(data_width),
    .TILE_BITS (DEFAULT_TILE_BITS)
  ) rf_bank_inst (
    .clk            (clk),
    .rst            (rst),
    .read_advance   (read_advance),
    .read0_addr     (read0_addr),
    .read0_const_en (read0_const_en),
    .read0_const    (read0_const),
    .read0_data     (read0_data),
    .read1_addr     (read1_addr),
    .read1_const_en (read1_const_en),
    .read1_const    (read1_const),
    .read1_data     (read1_data),
    .retire_advance (retire_advance),
    .retire_addr    (retire_addr),
    .retire_data    (retire_data),
    .write0_addr    (write0_addr),
    .write0_data    (write0_data),
    .write0_en      (write0_en),
    .write1_addr    (write1_addr),
    .write1_data    (write1_data),
    .write1_en      (write1_en),
    .ready          (ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  function automatic data_t expected_read(input logic valid, input addr_t addr,
                                          input logic const_en, input data_t const_value);
    if (!valid)
    begin
      return '0;
    end
    if (const_en)
    begin
      return const_value;
    end
    return shadow[addr];
  endfunction

  function automatic addr_t random_addr();
    return addr_t'($random(seed));
  endfunction

  function automatic data_t random_data();
    return data_t'($random(seed));
  endfunction

  task automatic check_value(input string what, input data_t got, input data_t expected);
    check_count++;
    assert (got === expected)
    else
    begin
      error_count++;
      $display("error at %0t: %s got %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic end_test(input int number, input string name, input int errors_before);
    $display("test %0d %s: %0d errors", number, name, error_count - errors_before);
  endtask

  // model follows the same write order as the bank, port 1 last
  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < num_addr; i++)
      begin
        shadow[i] = '0;
      end
      sweep_left    = num_addr;
      cap_valid     = 1'b0;
      retire_valid  = 1'b0;
      cap0_const_en = 1'b0;
      cap1_const_en = 1'b0;
    end
    else
    begin
      if (sweep_left > 0)
      begin
        sweep_left = sweep_left - 1;
      end
      else if (write0_en)
      begin
        shadow[write0_addr] = write0_data;
      end
      if (write1_en)
      begin
        shadow[write1_addr] = write1_data;
      end
      if (read_advance)
      begin
        cap_valid     = 1'b1;
        cap0_addr     = read0_addr;
        cap1_addr     = read1_addr;
        cap0_const_en = read0_const_en;
        cap1_const_en = read1_const_en;
        cap0_const    = read0_const;
        cap1_const    = read1_const;
      end
      if (retire_advance)
      begin
        retire_valid    = 1'b1;
        cap_retire_addr = retire_addr;
      end
    end
  end

  // outputs only change on rising edges, so the falling edge is a safe sample point
  always @(negedge clk)
  begin
    if (!rst && sweep_left == 0)
    begin
      check_count++;
      assert (ready === 1'b1)
      else
      begin
        error_count++;
        $display("error at %0t: ready is %b after the sweep, expected 1", $time, ready);
      end
      check_value("read0", read0_data,
                  expected_read(cap_valid, cap0_addr, cap0_const_en, cap0_const));
      check_value("read1", read1_data,
                  expected_read(cap_valid, cap1_addr, cap1_const_en, cap1_const));
      check_value("retire", retire_data,
                  expected_read(retire_valid, cap_retire_addr, 1'b0, '0));
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= cycle_limit)
    begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  initial
  begin
    int           low_cycles;
    int           errors_before;
    addr_t        held_addr;
    addr_t        written[$];
    sweep_state_e seen_state;

    seed           = 40;
    rst            = 1'b1;
    read_advance   = 1'b1;
    read0_addr     = '0;
    read0_const_en = 1'b0;
    read0_const    = '0;
    read1_addr     = '0;
    read1_const_en = 1'b0;
    read1_const    = '0;
    retire_advance = 1'b1;
    retire_addr    = '0;
    write0_addr    = '0;
    write0_data    = '0;
    write0_en      = 1'b0;
    write1_addr    = '0;
    write1_data    = '0;
    write1_en      = 1'b0;

    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;

    // test 1: sweep length, then every address reads zero
    errors_before = error_count;
    low_cycles    = 0;
    while (!ready && low_cycles <= num_addr)
    begin
      // external write0 during the sweep must be dropped
      write0_en   = 1'b1;
      write0_addr = random_addr();
      write0_data = random_data();
      @(negedge clk);
      low_cycles++;
    end
    write0_en = 1'b0;
    check_count++;
    assert (low_cycles == num_addr)
    else
    begin
      error_count++;
      $display("error at %0t: ready rose after %0d cycles, expected %0d",
               $time, low_cycles, num_addr);
    end
    seen_state = ready ? sweep_done : sweep_fill;
    for (int a = 0; a < num_addr; a++)
    begin
      read0_addr  = addr_t'(a);
      read1_addr  = addr_t'(num_addr - 1 - a);
      retire_addr = addr_t'(a);
      @(negedge clk);
    end
    end_test(1, $sformatf("sweep (ready after %0d cycles, %s)", low_cycles, seen_state.name()),
             errors_before);

    // test 2: random writes on both ports, a quarter of them colliding
    errors_before = error_count;
    for (int i = 0; i < random_ops; i++)
    begin
      write0_addr = random_addr();
      write1_addr = (($random(seed) & 3) == 0) ? write0_addr : random_addr();
      write0_data = random_data();
      write1_data = random_data();
      write0_en   = 1'b1;
      write1_en   = 1'b1;
      read0_addr  = random_addr();
      read1_addr  = write0_addr;
      written.push_back(write0_addr);
      written.push_back(write1_addr);
      @(negedge clk);
    end
    write0_en = 1'b0;
    write1_en = 1'b0;
    for (int i = 0; i < written.size(); i += 2)
    begin
      read0_addr = written[i];
      read1_addr = written[i+1];
      @(negedge clk);
    end
    end_test(2, "random writes and readback", errors_before);

    // test 3: const override on both read ports
    errors_before = error_count;
    for (int i = 0; i < const_ops; i++)
    begin
      read0_addr     = random_addr();
      read1_addr     = random_addr();
      read0_const_en = 1'($random(seed));
      read1_const_en = 1'($random(seed));
      read0_const    = random_data();
      read1_const    = random_data();
      write1_en      = (($random(seed) & 7) == 0);
      write1_addr    = read0_addr;
      write1_data    = random_data();
      @(negedge clk);
    end
    read0_const_en = 1'b0;
    read1_const_en = 1'b0;
    write1_en      = 1'b0;
    @(negedge clk);
    end_test(3, "const override", errors_before);

    // test 4: stalled reads hold the address and still see writes
    errors_before = error_count;
    for (int i = 0; i < stall_rounds; i++)
    begin
      read_advance = 1'b1;
      read0_addr   = random_addr();
      read1_addr   = random_addr();
      held_addr    = read0_addr;
      @(negedge clk);
      read_advance = 1'b0;
      for (int c = 0; c < 7; c++)
      begin
        read0_addr     = random_addr();
        read1_addr     = random_addr();
        read0_const_en = 1'b1;
        read0_const    = random_data();
        write1_en      = (c == 2);
        write1_addr    = held_addr;
        write1_data    = random_data();
        @(negedge clk);
      end
      read0_const_en = 1'b0;
      write1_en      = 1'b0;
    end
    read_advance = 1'b1;
    end_test(4, "read stall", errors_before);

    // test 5: retire port holds its address and never takes the const
    errors_before = error_count;
    for (int i = 0; i < retire_rounds; i++)
    begin
      retire_advance = 1'b1;
      retire_addr    = random_addr();
      held_addr      = retire_addr;
      read0_addr     = retire_addr;
      read0_const_en = 1'b1;
      read0_const    = random_data();
      @(negedge clk);
      retire_advance = 1'b0;
      for (int c = 0; c < 4; c++)
      begin
        retire_addr = random_addr();
        write1_en   = (c == 1);
        write1_addr = held_addr;
        write1_data = random_data();
        @(negedge clk);
      end
      write1_en = 1'b0;
    end
    read0_const_en = 1'b0;
    retire_advance = 1'b1;
    @(negedge clk);
    end_test(5, "retire read", errors_before);

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/rf_cfg_pkg.sv
rtl/rf_types_pkg.sv
rtl/rf_row_ram.sv
rtl/rf_tile.sv
rtl/rf_init_sweep.sv
rtl/rf_read_merge.sv
rtl/rf_bank.sv
verification/rf_bank_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := rf_bank_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Finished with no errors" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
